// ==== rtl/led_panel_top.sv ====
`include "panel_defs.svh"

module led_panel_top (
  input  logic                       clk,
  input  logic                       rst,
  input  panel_pkg::host_wr_t        host_wr,
  input  logic                       host_wr_en,
  output logic                       host_busy,
  input  logic                       cache,
  input  logic [`ROW_BITS-1:0]       row,
  input  logic [`PLANE_SEL_BITS-1:0] plane_select,
  input  logic                       shift_plane,
  output logic                       plane_ready,
  output panel_pkg::rgb_t            rgb0,
  output panel_pkg::rgb_t            rgb1,
  output logic                       vram_available
);
  import panel_pkg::*;

  logic                       we;
  logic                       re;
  logic                       rd;
  logic                       done_read;
  logic [`VRAM_ADDR_BITS-1:0] waddr;
  logic [`VRAM_ADDR_BITS-1:0] raddr;
  logic [`VRAM_ADDR_BITS-1:0] rd_addr;
  row_t                       wdata;
  row_t                       rd_data;
  row_t                       row0;
  row_t                       row1;
  logic                       row_load0;
  logic                       row_load1;
  plane_t                     plane;
  logic                       plane_load0;
  logic                       plane_load1;
  logic                       plane_shift;
  rgb_t [1:0]                 rgb01;

  vram_arbiter i_vram_arbiter (
    .clk, .rst, .host_wr, .host_wr_en, .host_busy, .rd, .rd_addr, .vram_available,
    .we, .waddr, .wdata, .re, .raddr
  );

  vram i_vram (
    .clk, .we, .waddr, .wdata, .re, .raddr, .rd_data, .done_read
  );

  row_cache i_row_cache (
    .clk, .rst, .rd_data, .row_load0, .row_load1, .row0, .row1
  );

  read_memory_management i_read_memory_management (
    .clk, .rst, .cache, .row, .plane_select, .shift_plane, .rgb01, .row0, .row1,
    .done_read, .plane_ready, .plane_load0, .plane_load1, .plane_shift, .row_load0,
    .row_load1, .rgb0, .rgb1, .plane, .rd_addr, .rd, .vram_available
  );

  plane_shifter i_plane_shifter (
    .clk, .rst, .plane, .plane_load0, .plane_load1, .plane_shift, .rgb01
  );

endmodule

// ==== rtl/panel_defs.svh ====
`ifndef PANEL_DEFS_SVH
`define PANEL_DEFS_SVH

// columns in one panel row
`define PANEL_COLS 16

// row address within one half of the panel
`define ROW_BITS 5

`define COLOR_BITS 4 // bits per colour channel, one bit plane per bit
`define PLANE_SEL_BITS $clog2(`COLOR_BITS)

// one extra bit selects the upper or the lower half
`define VRAM_ADDR_BITS (`ROW_BITS + 1)
`define VRAM_DEPTH (1 << `VRAM_ADDR_BITS)

`endif

// ==== rtl/panel_pkg.sv ====
`include "panel_defs.svh"

package panel_pkg;

  typedef struct packed {
    logic [`COLOR_BITS-1:0] red;
    logic [`COLOR_BITS-1:0] green;
    logic [`COLOR_BITS-1:0] blue;
  } pixel_t;

  typedef pixel_t [`PANEL_COLS-1:0] row_t; // one VRAM word, pixel k is column k

  // one bit plane of a row, bit k of each mask is column k
  typedef struct packed {
    logic [`PANEL_COLS-1:0] r;
    logic [`PANEL_COLS-1:0] g;
    logic [`PANEL_COLS-1:0] b;
  } plane_t;

  typedef struct packed {
    logic r;
    logic g;
    logic b;
  } rgb_t;

  typedef struct packed {
    logic [`VRAM_ADDR_BITS-1:0] addr;
    row_t                       data;
  } host_wr_t;

  typedef enum logic [3:0] {
    START,
    SHIFT_P,
    S_LOAD0,
    S_LOAD1,
    DONE,
    S_CACHE_ROW0,
    S_LOAD_ROW0,
    S_CACHE_ROW1,
    S_LOAD_ROW1
  } rmm_state_e;

endpackage

// ==== rtl/plane_shifter.sv ====
module plane_shifter (
  input  logic                  clk,
  input  logic                  rst,
  input  panel_pkg::plane_t     plane,
  input  logic                  plane_load0,
  input  logic                  plane_load1,
  input  logic                  plane_shift,
  output panel_pkg::rgb_t [1:0] rgb01
);
  import panel_pkg::*;

  plane_t [1:0] shreg; // index 1 is the upper half, index 0 the lower half
  logic   [1:0] load;

  assign load = {plane_load0, plane_load1};

  always_ff @(posedge clk) begin
    for (int h = 0; h < 2; h++) begin
      if (rst) begin
        shreg[h] <= '0;
      end else if (load[h]) begin
        shreg[h] <= plane;
      end else if (plane_shift) begin
        // next column moves down into bit 0
        shreg[h].r <= shreg[h].r >> 1;
        shreg[h].g <= shreg[h].g >> 1;
        shreg[h].b <= shreg[h].b >> 1;
      end
    end
  end

  always_comb begin
    for (int h = 0; h < 2; h++) begin
      rgb01[h].r = shreg[h].r[0];
      rgb01[h].g = shreg[h].g[0];
      rgb01[h].b = shreg[h].b[0];
    end
  end

endmodule

// ==== rtl/read_memory_management.sv ====
`include "panel_defs.svh"

module read_memory_management (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       cache,
  input  logic [`ROW_BITS-1:0]       row,
  input  logic [`PLANE_SEL_BITS-1:0] plane_select,
  input  logic                       shift_plane,
  input  panel_pkg::rgb_t [1:0]      rgb01,
  input  panel_pkg::row_t            row0,
  input  panel_pkg::row_t            row1,
  input  logic                       done_read,
  output logic                       plane_ready,
  output logic                       plane_load0,
  output logic                       plane_load1,
  output logic                       plane_shift,
  output logic                       row_load0,
  output logic                       row_load1,
  output panel_pkg::rgb_t            rgb0,
  output panel_pkg::rgb_t            rgb1,
  output panel_pkg::plane_t          plane,
  output logic [`VRAM_ADDR_BITS-1:0] rd_addr,
  output logic                       rd,
  output logic                       vram_available
);
  import panel_pkg::*;

  rmm_state_e           state;
  logic                 side; // 0 selects the upper row, 1 the lower row
  logic                 cached;
  logic [`ROW_BITS-1:0] cached_row;
  logic                 hit;
  row_t                 sel_row;

  assign hit     = cached && (row == cached_row);
  assign rd_addr = {side, cached_row};

  assign rgb0 = rgb01[1];
  assign rgb1 = rgb01[0];

  assign sel_row = side ? row1 : row0;

  // pick bit plane_select out of every colour of every pixel
  always_comb begin
    for (int k = 0; k < `PANEL_COLS; k++) begin
      plane.r[k] = sel_row[k].red[plane_select];
      plane.g[k] = sel_row[k].green[plane_select];
      plane.b[k] = sel_row[k].blue[plane_select];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= START;
      side           <= 1'b0;
      cached         <= 1'b0;
      vram_available <= 1'b1;
      rd             <= 1'b0;
      plane_shift    <= 1'b0;
      plane_load0    <= 1'b0;
      plane_load1    <= 1'b0;
      plane_ready    <= 1'b0;
      row_load0      <= 1'b0;
      row_load1      <= 1'b0;
    end else begin
      // every strobe lasts one cycle unless a state raises it again
      rd          <= 1'b0;
      plane_shift <= 1'b0;
      plane_load0 <= 1'b0;
      plane_load1 <= 1'b0;
      plane_ready <= 1'b0;
      row_load0   <= 1'b0;
      row_load1   <= 1'b0;
      case (state)
        START: begin
          side <= 1'b0;
          if (shift_plane && cached) begin
            plane_shift <= 1'b1;
            state       <= SHIFT_P;
          end else if (cache && hit) begin
            plane_load0 <= 1'b1; // rows already held, go straight to the planes
            state       <= S_LOAD0;
          end else if (cache) begin
            rd             <= 1'b1;
            cached         <= 1'b0;
            cached_row     <= row;
            vram_available <= 1'b0;
            state          <= S_CACHE_ROW0;
          end
        end
        SHIFT_P: begin
          if (shift_plane) begin
            plane_shift <= 1'b1;
          end else begin
            state <= START;
          end
        end
        S_LOAD0: begin
          plane_load1 <= 1'b1;
          side        <= 1'b1;
          state       <= S_LOAD1;
        end
        S_LOAD1: begin
          plane_ready <= 1'b1; // both shifters hold the plane by now
          side        <= 1'b0;
          state       <= DONE;
        end
        DONE: state <= START;
        S_CACHE_ROW0: begin
          if (done_read) begin
            row_load0 <= 1'b1;
            state     <= S_LOAD_ROW0;
          end
        end
        S_LOAD_ROW0: begin
          // second read fetches the matching lower half row
          rd    <= 1'b1;
          side  <= 1'b1;
          state <= S_CACHE_ROW1;
        end
        S_CACHE_ROW1: begin
          if (done_read) begin
            row_load1 <= 1'b1;
            state     <= S_LOAD_ROW1;
          end
        end
        S_LOAD_ROW1: begin
          plane_load0    <= 1'b1;
          side           <= 1'b0;
          cached         <= 1'b1;
          vram_available <= 1'b1; // host writes may proceed again
          state          <= S_LOAD0;
        end
        default: state <= START;
      endcase
    end
  end

  // read data only comes back while a row is being fetched into the cache
  a_done_read_expected: assert property (
    @(posedge clk) disable iff (rst)
    done_read |-> (state == S_CACHE_ROW0 || state == S_CACHE_ROW1))
    else $error("read_memory_management: done_read outside a row fetch");

endmodule

// ==== rtl/row_cache.sv ====
module row_cache (
  input  logic            clk,
  input  logic            rst,
  input  panel_pkg::row_t rd_data,
  input  logic            row_load0,
  input  logic            row_load1,
  output panel_pkg::row_t row0,
  output panel_pkg::row_t row1
);

  // row0 is the upper half line, row1 the lower half line scanned with it
  always_ff @(posedge clk) begin
    if (rst) begin
      row0 <= '0;
      row1 <= '0;
    end else begin
      if (row_load0) begin
        row0 <= rd_data;
      end
      if (row_load1) begin
        row1 <= rd_data;
      end
    end
  end

endmodule

// ==== rtl/vram.sv ====
`include "panel_defs.svh"

module vram (
  input  logic                       clk,
  input  logic                       we,
  input  logic [`VRAM_ADDR_BITS-1:0] waddr,
  input  panel_pkg::row_t            wdata,
  input  logic                       re,
  input  logic [`VRAM_ADDR_BITS-1:0] raddr,
  output panel_pkg::row_t            rd_data,
  output logic                       done_read
);
  import panel_pkg::*;

  // upper half at addresses 0..31, lower half at 32..63
  row_t mem [0:`VRAM_DEPTH-1];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // read data stays put until the next read enable
  always_ff @(posedge clk) begin
    if (re) begin
      rd_data <= mem[raddr];
    end
  end

  always_ff @(posedge clk) begin
    done_read <= re; // one cycle after every read enable
  end

  // the arbiter in front has to keep host writes off the port during reads
  a_no_rw_collision: assert property (@(posedge clk) !(we && re))
    else $error("vram: write and read enable high in the same cycle");

endmodule

// ==== rtl/vram_arbiter.sv ====
`include "panel_defs.svh"

module vram_arbiter (
  input  logic                       clk,
  input  logic                       rst,
  input  panel_pkg::host_wr_t        host_wr,
  input  logic                       host_wr_en,
  output logic                       host_busy,
  input  logic                       rd,
  input  logic [`VRAM_ADDR_BITS-1:0] rd_addr,
  input  logic                       vram_available,
  output logic                       we,
  output logic [`VRAM_ADDR_BITS-1:0] waddr,
  output panel_pkg::row_t            wdata,
  output logic                       re,
  output logic [`VRAM_ADDR_BITS-1:0] raddr
);
  import panel_pkg::*;

  host_wr_t pending;
  host_wr_t wr_sel;
  logic     pending_valid;
  logic     reader_idle;

  // the reader owns the memory for the whole caching sequence
  assign reader_idle = vram_available && !rd;

  // a held write goes first, otherwise a fresh strobe writes straight through
  assign wr_sel = pending_valid ? pending : host_wr;
  assign we     = reader_idle && (pending_valid || host_wr_en);
  assign waddr  = wr_sel.addr;
  assign wdata  = wr_sel.data;

  assign re    = rd; // reads are never delayed
  assign raddr = rd_addr;

  assign host_busy = pending_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending_valid <= 1'b0;
    end else if (pending_valid && reader_idle) begin
      pending_valid <= 1'b0;
    end else if (host_wr_en && !reader_idle) begin
      pending_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (host_wr_en && !pending_valid) begin
      pending <= host_wr;
    end
  end

  // only one write can be held, so the host has to wait while busy
  a_no_strobe_when_busy: assert property (
    @(posedge clk) disable iff (rst) host_busy |-> !host_wr_en)
    else $error("vram_arbiter: host write strobed while host_busy");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_led_panel

status=0
./obj_dir/Vtb_led_panel > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
exit 0

// ==== tb.f ====
+incdir+rtl
rtl/panel_pkg.sv
rtl/vram.sv
rtl/vram_arbiter.sv
rtl/row_cache.sv
rtl/read_memory_management.sv
rtl/plane_shifter.sv
rtl/led_panel_top.sv
verification/tb_led_panel.sv

// ==== verification/tb_led_panel.sv ====
`include "panel_defs.svh"

module tb_led_panel;
  timeunit 1ns;
  timeprecision 1ps;
  import panel_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int NUM_RANDOM   = 6;
  localparam int NUM_REQUESTS = NUM_RANDOM + 10; // tests 3 to 6 issue ten more
  localparam int READY_LIMIT  = 100;
  localparam int COL_BITS     = $clog2(`PANEL_COLS);

  logic                       clk;
  logic                       rst;
  host_wr_t                   host_wr;
  logic                       host_wr_en;
  logic                       host_busy;
  logic                       cache;
  logic [`ROW_BITS-1:0]       row;
  logic [`PLANE_SEL_BITS-1:0] plane_select;
  logic                       shift_plane;
  logic                       plane_ready;
  rgb_t                       rgb0;
  rgb_t                       rgb1;
  logic                       vram_available;

  integer               seed;
  int                   errors; // checks failed in the running test
  int                   total_errors;
  int                   tests_run;
  int                   tests_failed;
  row_t                 model [0:`VRAM_DEPTH-1];
  row_t                 exp_up; // rows the DUT should hold in its cache
  row_t                 exp_lo;
  logic [`ROW_BITS-1:0] crow;
  logic                 cvalid;

  led_panel_top i_led_panel_top (
    .clk, .rst, .host_wr, .host_wr_en, .host_busy, .cache, .row, .plane_select,
    .shift_plane, .plane_ready, .rgb0, .rgb1, .vram_available
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // one column of one bit plane as the panel shows it
  function automatic rgb_t column_bits(row_t data, logic [`PLANE_SEL_BITS-1:0] p,
                                       logic [COL_BITS-1:0] k);
    rgb_t c;
    c.r = data[k].red[p];
    c.g = data[k].green[p];
    c.b = data[k].blue[p];
    return c;
  endfunction

  task automatic random_row(output row_t d);
    logic [$bits(row_t)-1:0] bits;
    for (int i = 0; i < $bits(row_t) / 32; i++) begin
      bits[i*32 +: 32] = $random(seed);
    end
    d = bits;
  endtask

  task automatic host_write(input logic [`VRAM_ADDR_BITS-1:0] addr, input row_t data);
    int waited;
    waited = 0;
    while (host_busy && waited < READY_LIMIT) begin
      @(posedge clk);
      @(negedge clk);
      waited++;
    end
    if (host_busy) begin
      $display("host_busy stuck high at %0t, write to address %0d dropped", $time, addr);
      errors++;
    end else begin
      host_wr.addr = addr;
      host_wr.data = data;
      host_wr_en   = 1'b1;
      model[addr]  = data; // read priority still lets this land before any later read
      @(posedge clk);
      @(negedge clk);
      host_wr_en = 1'b0;
    end
  endtask

  // strobes cache and waits for plane_ready, optionally slipping a host write into a miss
  task automatic request_row(input logic [`ROW_BITS-1:0] r,
                             input logic [`PLANE_SEL_BITS-1:0] p, input bit inject,
                             input host_wr_t wr, output int edges, output bit ok,
                             output bit dropped);
    row = r;
    plane_select = p;
    cache = 1'b1;
    if (!(cvalid && crow == r)) begin
      exp_up = model[{1'b0, r}];
      exp_lo = model[{1'b1, r}];
      crow   = r;
      cvalid = 1'b1;
    end
    edges   = 0;
    ok      = 1'b0;
    dropped = 1'b0;
    while (!ok && edges < READY_LIMIT) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      cache = 1'b0;
      if (!vram_available) dropped = 1'b1;
      if (inject && edges == 1) begin
        if (vram_available !== 1'b0) begin
          $display("Mismatch at %0t: vram_available expected 0 got %b", $time,
                   vram_available);
          errors++;
        end
        host_wr      = wr;
        host_wr_en   = 1'b1;
        model[wr.addr] = wr.data;
      end else if (inject && edges == 2) begin
        host_wr_en = 1'b0;
        if (host_busy !== 1'b1) begin
          $display("Mismatch at %0t: host_busy expected 1 got %b", $time, host_busy);
          errors++;
        end
      end
      ok = plane_ready;
    end
    if (!ok) begin
      $display("plane_ready never arrived within %0d cycles for row %0d", READY_LIMIT, r);
      errors++;
    end else begin
      @(posedge clk); // DONE back to START
      @(negedge clk);
    end
  endtask

  task automatic check_shift_out(input logic [`PLANE_SEL_BITS-1:0] p);
    rgb_t want0;
    rgb_t want1;
    shift_plane = 1'b1;
    for (int k = 0; k < `PANEL_COLS; k++) begin
      @(posedge clk);
      @(negedge clk);
      want0 = column_bits(exp_up, p, k[COL_BITS-1:0]);
      want1 = column_bits(exp_lo, p, k[COL_BITS-1:0]);
      if (rgb0 !== want0) begin
        $display("Mismatch at %0t: rgb0 column %0d expected %b got %b", $time, k, want0, rgb0);
        errors++;
      end
      if (rgb1 !== want1) begin
        $display("Mismatch at %0t: rgb1 column %0d expected %b got %b", $time, k, want1, rgb1);
        errors++;
      end
      if (k == `PANEL_COLS - 1) shift_plane = 1'b0;
    end
    @(posedge clk); // last shift and return to START
    @(negedge clk);
  endtask

  task automatic read_and_check(input logic [`ROW_BITS-1:0] r,
                                input logic [`PLANE_SEL_BITS-1:0] p);
    int edges;
    bit ok;
    bit dropped;
    request_row(r, p, 1'b0, '0, edges, ok, dropped);
    if (ok) check_shift_out(p);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    total_errors += errors;
    if (errors == 0) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", name, errors);
    end
    errors = 0;
  endtask

  initial begin
    logic [`ROW_BITS-1:0]       r;
    logic [`ROW_BITS-1:0]       r_other;
    logic [`PLANE_SEL_BITS-1:0] p;
    logic [31:0]                rnd;
    row_t                       data;
    host_wr_t                   wr;
    int                         edges;
    bit                         ok;
    bit                         dropped;

    seed = 32'hd10bd4e6;
    clk = 1'b0;
    rst = 1'b1;
    host_wr = '0;
    host_wr_en = 1'b0;
    cache = 1'b0;
    row = '0;
    plane_select = '0;
    shift_plane = 1'b0;
    errors = 0;
    total_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    cvalid = 1'b0;
    crow = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    if (plane_ready !== 1'b0) begin
      $display("Mismatch at %0t: plane_ready expected 0 got %b", $time, plane_ready);
      errors++;
    end
    if (host_busy !== 1'b0) begin
      $display("Mismatch at %0t: host_busy expected 0 got %b", $time, host_busy);
      errors++;
    end
    if (vram_available !== 1'b1) begin
      $display("Mismatch at %0t: vram_available expected 1 got %b", $time, vram_available);
      errors++;
    end
    finish_test("reset");

    for (int a = 0; a < `VRAM_DEPTH; a++) begin
      random_row(data);
      host_write(a[`VRAM_ADDR_BITS-1:0], data);
    end
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rnd = $random(seed);
      read_and_check(rnd[`ROW_BITS-1:0], rnd[`ROW_BITS +: `PLANE_SEL_BITS]);
    end
    finish_test("full-row readout");

    rnd = $random(seed);
    r = rnd[`ROW_BITS-1:0];
    for (int q = 0; q < `COLOR_BITS; q++) begin
      read_and_check(r, q[`PLANE_SEL_BITS-1:0]);
    end
    finish_test("all planes");

    // r is still cached from the plane sweep
    rnd = $random(seed);
    p = rnd[`PLANE_SEL_BITS-1:0];
    read_and_check(r, p);
    request_row(r, p, 1'b0, '0, edges, ok, dropped);
    if (ok && edges != 3) begin
      $display("Mismatch at %0t: plane_ready latency expected 3 got %0d", $time, edges);
      errors++;
    end
    if (dropped) begin
      $display("Mismatch at %0t: vram_available during a cache hit expected 1 got 0", $time);
      errors++;
    end
    if (ok) check_shift_out(p);
    finish_test("cache hit");

    rnd = $random(seed);
    r = crow ^ {rnd[`ROW_BITS-1:1], 1'b1}; // forces a miss
    r_other = r ^ {rnd[2*`ROW_BITS-2:`ROW_BITS], 1'b1};
    p = rnd[2*`ROW_BITS +: `PLANE_SEL_BITS];
    random_row(data);
    wr.addr = {rnd[31], r_other};
    wr.data = data;
    request_row(r, p, 1'b1, wr, edges, ok, dropped);
    if (host_busy !== 1'b0) begin
      $display("Mismatch at %0t: host_busy expected 0 got %b", $time, host_busy);
      errors++;
    end
    if (ok) check_shift_out(p);
    read_and_check(r_other, p);
    finish_test("host write during miss");

    rnd = $random(seed);
    r = rnd[`ROW_BITS-1:0];
    r_other = r ^ {rnd[2*`ROW_BITS-2:`ROW_BITS], 1'b1};
    p = rnd[2*`ROW_BITS +: `PLANE_SEL_BITS];
    read_and_check(r, p);
    random_row(data);
    host_write({1'b0, r_other}, data);
    random_row(data);
    host_write({1'b1, r_other}, data);
    read_and_check(r_other, p);
    finish_test("row change");

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, total_errors);
    if (tests_failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(200 * NUM_REQUESTS * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish",
             200 * NUM_REQUESTS);
    $display("Test failed");
    $finish;
  end

endmodule
